/* fsync_pkg.sv */
// Sync core shared definitions
`default_nettype none

package fsync_pkg;

  // --------------------
  // widths.
  // --------------------
  localparam int N_PORTS     = 2;  // one request port per child direction.
  localparam int AGGR_WIDTH  = 4;  // aggregation mask, also the number of levels.
  localparam int LEVEL_WIDTH = 2;
  localparam int ID_WIDTH    = 3;
  localparam int SD_WIDTH    = 2;  // source / destination code.

  localparam logic [1:0] SD_BOTH = 2'b11;  // appended to an upward source.

  // per-port control FSM.
  typedef enum logic {
    IDLE,
    CHECK
  } ctrl_state_e;

  // --------------------
  // queue elements.
  // --------------------
  typedef struct packed {
    logic                error;  // set for bad id or repeated arrival.
    logic [SD_WIDTH-1:0] dst;
  } local_rsp_t;

  typedef struct packed {
    logic [AGGR_WIDTH-1:0] aggr;  // already shifted down one level.
    logic [ID_WIDTH-1:0]   id;
    logic [SD_WIDTH+1:0]   src;   // source followed by SD_BOTH.
  } remote_req_t;

endpackage

`default_nettype wire

/* fsync_rf_if.sv */
// Control to register file link
`timescale 1ns/10ps
`default_nettype none

interface fsync_rf_if;

  // lookup request, one lane per port.
  logic                             check   [fsync_pkg::N_PORTS];  // lookup strobe.
  logic [fsync_pkg::LEVEL_WIDTH-1:0] level  [fsync_pkg::N_PORTS];
  logic [fsync_pkg::ID_WIDTH-1:0]   id      [fsync_pkg::N_PORTS];

  // combinational lookup result.
  logic                             present [fsync_pkg::N_PORTS];  // other port was waiting.
  logic                             sig_err [fsync_pkg::N_PORTS];  // same port arrived twice.

  modport ctrl (
    output check,
    output level,
    output id,
    input  present,
    input  sig_err
  );

  modport rf (
    input  check,
    input  level,
    input  id,
    output present,
    output sig_err
  );

endinterface

`default_nettype wire

/* fsync_req_decode.sv */
// Request decoder
`timescale 1ns/10ps
`default_nettype none

module fsync_req_decode #(
  parameter int N_IDS = 6
) (
  input  logic [fsync_pkg::AGGR_WIDTH-1:0]  aggr_i,
  input  logic [fsync_pkg::ID_WIDTH-1:0]    id_i,
  input  logic [fsync_pkg::SD_WIDTH-1:0]    src_i,
  output logic [fsync_pkg::LEVEL_WIDTH-1:0] level_o,
  output logic                              id_err_o,
  output fsync_pkg::remote_req_t            remote_o
);

  // --------------------
  // level encoder.
  // --------------------
  // highest set bit wins, empty mask maps to level 0.
  always_comb begin : enc
    level_o = '0;
    for (int j = 0; j < fsync_pkg::AGGR_WIDTH; j++) begin
      if (aggr_i[j]) begin
        level_o = fsync_pkg::LEVEL_WIDTH'(j);  // later (higher) bits override.
      end
    end
  end

  // ids past the table size are never looked up.
  assign id_err_o = (int'(id_i) >= N_IDS);

  // --------------------
  // upward record.
  // --------------------
  assign remote_o.aggr = aggr_i >> 1;                   // one level closer to the root.
  assign remote_o.id   = id_i;                          // barrier keeps its id.
  assign remote_o.src  = {src_i, fsync_pkg::SD_BOTH};   // both children took part.

endmodule

`default_nettype wire

/* fsync_ctrl.sv */
// Sync core control
`timescale 1ns/10ps
`default_nettype none

module fsync_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_valid_i    [fsync_pkg::N_PORTS],
  input  logic                              root_i         [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::LEVEL_WIDTH-1:0] level_i        [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::ID_WIDTH-1:0]    id_i           [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::SD_WIDTH-1:0]    src_i          [fsync_pkg::N_PORTS],
  input  logic                              id_err_i       [fsync_pkg::N_PORTS],
  input  logic                              local_full_i   [fsync_pkg::N_PORTS],
  input  logic                              local_empty_i  [fsync_pkg::N_PORTS],
  input  logic                              local_pop_i    [fsync_pkg::N_PORTS],
  input  logic                              remote_full_i  [fsync_pkg::N_PORTS],
  input  logic                              remote_empty_i [fsync_pkg::N_PORTS],
  input  logic                              remote_pop_i   [fsync_pkg::N_PORTS],
  fsync_rf_if.ctrl                          rf_o,
  output logic                              push_local_o   [fsync_pkg::N_PORTS],
  output logic                              push_remote_o  [fsync_pkg::N_PORTS],
  output fsync_pkg::local_rsp_t             local_rsp_o    [fsync_pkg::N_PORTS],
  output logic                              detected_error_o [fsync_pkg::N_PORTS]
);

  fsync_pkg::ctrl_state_e state_q [fsync_pkg::N_PORTS];
  fsync_pkg::ctrl_state_e state_d [fsync_pkg::N_PORTS];
  logic                   accept  [fsync_pkg::N_PORTS];  // strobe seen while idle.
  logic                   rsp_err [fsync_pkg::N_PORTS];

  // --------------------
  // check FSMs.
  // --------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    for (int p = 0; p < fsync_pkg::N_PORTS; p++) begin
      if (!rst_ni) state_q[p] <= fsync_pkg::IDLE;
      else         state_q[p] <= state_d[p];
    end
  end

  always_comb begin : fsm_and_lookup
    for (int p = 0; p < fsync_pkg::N_PORTS; p++) begin
      accept[p] = req_valid_i[p] && (state_q[p] == fsync_pkg::IDLE);
      unique case (state_q[p])
        fsync_pkg::IDLE:  state_d[p] = accept[p] ? fsync_pkg::CHECK : fsync_pkg::IDLE;
        fsync_pkg::CHECK: state_d[p] = fsync_pkg::IDLE;  // strobes here are dropped.
        default:          state_d[p] = fsync_pkg::IDLE;
      endcase
      rf_o.check[p] = accept[p] & ~id_err_i[p];  // bad ids skip the table.
      rf_o.level[p] = level_i[p];
      rf_o.id[p]    = id_i[p];
    end
  end

  // push decision, same cycle as the accept.
  always_comb begin : decide
    for (int p = 0; p < fsync_pkg::N_PORTS; p++) begin
      rsp_err[p]           = id_err_i[p] | rf_o.sig_err[p];
      push_local_o[p]      = accept[p] & (rsp_err[p] | (rf_o.present[p] & root_i[p]));
      push_remote_o[p]     = accept[p] & ~rsp_err[p] & rf_o.present[p] & ~root_i[p];
      local_rsp_o[p].error = rsp_err[p];
      local_rsp_o[p].dst   = src_i[p];  // wake goes back to the requester.
    end
  end

  // --------------------
  // queue misuse.
  // --------------------
  for (genvar p = 0; p < fsync_pkg::N_PORTS; p++) begin : gen_err
    assign detected_error_o[p] = (local_full_i[p] & push_local_o[p])     // overflow.
                               | (local_empty_i[p] & local_pop_i[p])     // underflow.
                               | (remote_full_i[p] & push_remote_o[p])
                               | (remote_empty_i[p] & remote_pop_i[p]);
  end

endmodule

`default_nettype wire

/* fsync_rf.sv */
// Barrier register file
`timescale 1ns/10ps
`default_nettype none

module fsync_rf #(
  parameter int N_IDS = 6
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  fsync_rf_if.rf rf_i
);

  localparam int PORT_WIDTH = (fsync_pkg::N_PORTS > 1) ? $clog2(fsync_pkg::N_PORTS) : 1;

  // one entry per level and id.
  logic                  valid_q [fsync_pkg::AGGR_WIDTH][N_IDS];  // a port is waiting.
  logic                  valid_d [fsync_pkg::AGGR_WIDTH][N_IDS];
  logic [PORT_WIDTH-1:0] port_q  [fsync_pkg::AGGR_WIDTH][N_IDS];  // which port waits.
  logic [PORT_WIDTH-1:0] port_d  [fsync_pkg::AGGR_WIDTH][N_IDS];

  // --------------------
  // lookup and update.
  // --------------------
  // ports resolve in index order, each one sees the updates of the lower ports.
  always_comb begin : lookup
    logic [fsync_pkg::LEVEL_WIDTH-1:0] lvl;
    logic [fsync_pkg::ID_WIDTH-1:0]    idx;
    valid_d = valid_q;
    port_d  = port_q;
    for (int p = 0; p < fsync_pkg::N_PORTS; p++) begin
      lvl             = rf_i.level[p];
      idx             = rf_i.id[p];
      rf_i.present[p] = 1'b0;
      rf_i.sig_err[p] = 1'b0;
      if (rf_i.check[p]) begin
        if (!valid_d[lvl][idx]) begin
          valid_d[lvl][idx] = 1'b1;  // first arrival waits.
          port_d[lvl][idx]  = PORT_WIDTH'(p);
        end else if (port_d[lvl][idx] == PORT_WIDTH'(p)) begin
          rf_i.sig_err[p] = 1'b1;    // same port again, entry kept.
        end else begin
          rf_i.present[p]   = 1'b1;  // barrier complete.
          valid_d[lvl][idx] = 1'b0;
        end
      end
    end
  end

  // --------------------
  // storage.
  // --------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int l = 0; l < fsync_pkg::AGGR_WIDTH; l++) begin
        for (int i = 0; i < N_IDS; i++) begin
          valid_q[l][i] <= 1'b0;  // empty table.
        end
      end
    end else begin
      valid_q <= valid_d;
    end
  end

  // waiting port of each entry.
  always_ff @(posedge clk_i) begin
    port_q <= port_d;
  end

endmodule

`default_nettype wire

/* fsync_fifo.sv */
// Small synchronous queue
`timescale 1ns/10ps
`default_nettype none

module fsync_fifo #(
  parameter int  FIFO_DEPTH = 4,
  parameter type element_t  = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  element_t element_i,
  input  logic     pop_i,
  output element_t element_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  element_t             mem_q [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;  // occupancy.
  logic                 do_push, do_pop;

  // circular increment.
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o   = (count_q == '0);
  assign full_o    = (count_q == CNT_WIDTH'(FIFO_DEPTH));
  assign do_push   = push_i & ~full_o;   // overflow is dropped.
  assign do_pop    = pop_i & ~empty_o;   // underflow does nothing.
  assign element_o = mem_q[rd_ptr_q];    // head, valid while not empty.

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + CNT_WIDTH'(do_push) - CNT_WIDTH'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= element_i;
  end

endmodule

`default_nettype wire

/* fsync_cc.sv */
// Sync control core top
`timescale 1ns/10ps
`default_nettype none

module fsync_cc #(
  parameter int N_IDS      = 6,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_valid_i      [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::AGGR_WIDTH-1:0]  req_aggr_i       [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::ID_WIDTH-1:0]    req_id_i         [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::SD_WIDTH-1:0]    req_src_i        [fsync_pkg::N_PORTS],
  input  logic                              root_i           [fsync_pkg::N_PORTS],
  input  logic                              local_pop_i      [fsync_pkg::N_PORTS],
  input  logic                              remote_pop_i     [fsync_pkg::N_PORTS],
  output logic                              local_empty_o    [fsync_pkg::N_PORTS],
  output logic                              local_error_o    [fsync_pkg::N_PORTS],
  output logic [fsync_pkg::SD_WIDTH-1:0]    local_dst_o      [fsync_pkg::N_PORTS],
  output logic                              remote_empty_o   [fsync_pkg::N_PORTS],
  output logic [fsync_pkg::AGGR_WIDTH-1:0]  remote_aggr_o    [fsync_pkg::N_PORTS],
  output logic [fsync_pkg::ID_WIDTH-1:0]    remote_id_o      [fsync_pkg::N_PORTS],
  output logic [fsync_pkg::SD_WIDTH+1:0]    remote_src_o     [fsync_pkg::N_PORTS],
  output logic                              detected_error_o [fsync_pkg::N_PORTS]
);

  logic [fsync_pkg::LEVEL_WIDTH-1:0] level       [fsync_pkg::N_PORTS];
  logic                              id_err      [fsync_pkg::N_PORTS];
  fsync_pkg::remote_req_t            remote_req  [fsync_pkg::N_PORTS];  // to remote queue.
  fsync_pkg::remote_req_t            remote_head [fsync_pkg::N_PORTS];
  fsync_pkg::local_rsp_t             local_rsp   [fsync_pkg::N_PORTS];  // to local queue.
  fsync_pkg::local_rsp_t             local_head  [fsync_pkg::N_PORTS];
  logic                              push_local  [fsync_pkg::N_PORTS];
  logic                              push_remote [fsync_pkg::N_PORTS];
  logic                              local_full  [fsync_pkg::N_PORTS];
  logic                              remote_full [fsync_pkg::N_PORTS];

  fsync_rf_if rf_bus ();  // lookup lanes between control and table.

  // --------------------
  // per-port decode and queues.
  // --------------------
  for (genvar p = 0; p < fsync_pkg::N_PORTS; p++) begin : gen_port
    fsync_req_decode #(.N_IDS(N_IDS)) i_decode (
      .aggr_i(req_aggr_i[p]), .id_i(req_id_i[p]), .src_i(req_src_i[p]),
      .level_o(level[p]), .id_err_o(id_err[p]), .remote_o(remote_req[p])
    );
    fsync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .element_t(fsync_pkg::local_rsp_t)) i_local_fifo (
      .clk_i, .rst_ni, .push_i(push_local[p]), .element_i(local_rsp[p]),
      .pop_i(local_pop_i[p]), .element_o(local_head[p]),
      .empty_o(local_empty_o[p]), .full_o(local_full[p])
    );
    fsync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .element_t(fsync_pkg::remote_req_t)) i_remote_fifo (
      .clk_i, .rst_ni, .push_i(push_remote[p]), .element_i(remote_req[p]),
      .pop_i(remote_pop_i[p]), .element_o(remote_head[p]),
      .empty_o(remote_empty_o[p]), .full_o(remote_full[p])
    );
    // queue heads split into plain fields.
    assign local_error_o[p] = local_head[p].error;
    assign local_dst_o[p]   = local_head[p].dst;
    assign remote_aggr_o[p] = remote_head[p].aggr;
    assign remote_id_o[p]   = remote_head[p].id;
    assign remote_src_o[p]  = remote_head[p].src;
  end

  // --------------------
  // control and table.
  // --------------------
  fsync_ctrl i_ctrl (
    .clk_i, .rst_ni, .req_valid_i, .root_i,
    .level_i(level), .id_i(req_id_i), .src_i(req_src_i), .id_err_i(id_err),
    .local_full_i(local_full), .local_empty_i(local_empty_o), .local_pop_i,
    .remote_full_i(remote_full), .remote_empty_i(remote_empty_o), .remote_pop_i,
    .rf_o(rf_bus), .push_local_o(push_local), .push_remote_o(push_remote),
    .local_rsp_o(local_rsp), .detected_error_o
  );

  fsync_rf #(.N_IDS(N_IDS)) i_rf (.clk_i, .rst_ni, .rf_i(rf_bus));

endmodule

`default_nettype wire

/* fsync_cc_props.sv */
// Sync core control properties
`timescale 1ns/10ps
`default_nettype none

module fsync_cc_props (
  input logic                   clk_i,
  input logic                   rst_ni,
  input fsync_pkg::ctrl_state_e state_i        [fsync_pkg::N_PORTS],
  input logic                   req_valid_i    [fsync_pkg::N_PORTS],
  input logic                   push_local_i   [fsync_pkg::N_PORTS],
  input logic                   push_remote_i  [fsync_pkg::N_PORTS],
  input logic                   local_empty_i  [fsync_pkg::N_PORTS],
  input logic                   remote_empty_i [fsync_pkg::N_PORTS],
  input logic                   error_i        [fsync_pkg::N_PORTS]
);

  for (genvar p = 0; p < fsync_pkg::N_PORTS; p++) begin : gen_port
    // first edge out of reset sees a clean port.
    a_reset_clean: assert property (@(posedge clk_i) $rose(rst_ni) |->
        (state_i[p] == fsync_pkg::IDLE) && local_empty_i[p] && remote_empty_i[p] && !error_i[p])
      else $error("port %0d not idle and empty after reset", p);

    a_check_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_i[p] == fsync_pkg::CHECK) |=> (state_i[p] == fsync_pkg::IDLE))
      else $error("port %0d stayed in CHECK", p);  // check lasts one cycle.

    a_one_queue: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push_local_i[p] && push_remote_i[p]))
      else $error("port %0d pushed both queues", p);

    a_push_on_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push_local_i[p] || push_remote_i[p]) |->
        (req_valid_i[p] && (state_i[p] == fsync_pkg::IDLE)))
      else $error("port %0d pushed without an accepted strobe", p);
  end

endmodule

`default_nettype wire

/* fsync_cc_checker.sv */
// Sync core reference checker
`timescale 1ns/10ps
`default_nettype none

module fsync_cc_checker #(
  parameter int N_IDS      = 6,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [2:0]                        phase_i,
  input  logic                              req_valid_i      [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::AGGR_WIDTH-1:0]  req_aggr_i       [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::ID_WIDTH-1:0]    req_id_i         [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::SD_WIDTH-1:0]    req_src_i        [fsync_pkg::N_PORTS],
  input  logic                              root_i           [fsync_pkg::N_PORTS],
  input  logic                              local_pop_i      [fsync_pkg::N_PORTS],
  input  logic                              remote_pop_i     [fsync_pkg::N_PORTS],
  input  logic                              local_empty_i    [fsync_pkg::N_PORTS],
  input  logic                              local_error_i    [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::SD_WIDTH-1:0]    local_dst_i      [fsync_pkg::N_PORTS],
  input  logic                              remote_empty_i   [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::AGGR_WIDTH-1:0]  remote_aggr_i    [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::ID_WIDTH-1:0]    remote_id_i      [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::SD_WIDTH+1:0]    remote_src_i     [fsync_pkg::N_PORTS],
  input  logic                              detected_error_i [fsync_pkg::N_PORTS],
  output int                                error_count_o
);

  localparam int NP = fsync_pkg::N_PORTS;
  localparam int AW = fsync_pkg::AGGR_WIDTH;

  bit                     valid_m  [AW][N_IDS];  // model of the barrier table.
  int                     owner_m  [AW][N_IDS];
  bit                     busy_m   [NP];         // port in its check cycle.
  fsync_pkg::local_rsp_t  local_m  [NP][$];
  fsync_pkg::remote_req_t remote_m [NP][$];
  int                     errors = 0;

  assign error_count_o = errors;

  function automatic string phase_name(input logic [2:0] ph);
    case (ph)
      3'd0:    return "reset";
      3'd1:    return "root_match";
      3'd2:    return "remote_match";
      3'd3:    return "same_entry";
      3'd4:    return "error_cases";
      3'd5:    return "queue_limits";
      default: return "drain";
    endcase
  endfunction

  task automatic compare(input string what, input int p, input logic [31:0] exp,
                         input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s port %0d %s: expected %0h, actual %0h",
               phase_name(phase_i), p, what, exp, act);
    end
  endtask

  // --------------------
  // model, one step per clock edge.
  // --------------------
  always @(posedge clk_i or negedge rst_ni) begin : model
    fsync_pkg::local_rsp_t  rsp;
    fsync_pkg::remote_req_t req;
    int                     lvl;
    bit                     acc;
    bit                     push_l;
    bit                     push_r;
    bit                     l_full;
    bit                     r_full;
    bit                     exp_err;
    if (!rst_ni) begin
      for (int l = 0; l < AW; l++) begin
        for (int i = 0; i < N_IDS; i++) valid_m[l][i] = 1'b0;
      end
      for (int p = 0; p < NP; p++) begin
        busy_m[p] = 1'b0;
        local_m[p].delete();
        remote_m[p].delete();
      end
    end else begin
      // port 0 first, so port 1 sees its table update.
      for (int p = 0; p < NP; p++) begin
        acc       = req_valid_i[p] && !busy_m[p];
        busy_m[p] = acc;
        push_l    = 1'b0;
        push_r    = 1'b0;
        rsp.error = 1'b1;
        rsp.dst   = req_src_i[p];          // answer goes to the requester.
        req.aggr  = req_aggr_i[p] >> 1;    // one level up.
        req.id    = req_id_i[p];
        req.src   = {req_src_i[p], 2'b11};  // both children joined.
        if (acc) begin
          lvl = 0;
          for (int j = 0; j < AW; j++) begin
            if (req_aggr_i[p][j]) lvl = j;  // highest set bit.
          end
          if (int'(req_id_i[p]) >= N_IDS) begin
            push_l = 1'b1;
          end else if (!valid_m[lvl][req_id_i[p]]) begin
            valid_m[lvl][req_id_i[p]] = 1'b1;
            owner_m[lvl][req_id_i[p]] = p;
          end else if (owner_m[lvl][req_id_i[p]] == p) begin
            push_l = 1'b1;                  // repeat, entry kept.
          end else begin
            valid_m[lvl][req_id_i[p]] = 1'b0;
            rsp.error = 1'b0;
            push_l    = root_i[p];
            push_r    = !root_i[p];
          end
        end
        l_full  = (local_m[p].size() == FIFO_DEPTH);
        r_full  = (remote_m[p].size() == FIFO_DEPTH);
        exp_err = (push_l && l_full) || (local_pop_i[p] && local_m[p].size() == 0)
               || (push_r && r_full) || (remote_pop_i[p] && remote_m[p].size() == 0);
        compare("local_empty", p, local_m[p].size() == 0, local_empty_i[p]);
        compare("remote_empty", p, remote_m[p].size() == 0, remote_empty_i[p]);
        compare("detected_error", p, exp_err, detected_error_i[p]);
        if (local_pop_i[p] && local_m[p].size() > 0) begin
          compare("local_rsp", p, local_m[p][0], {local_error_i[p], local_dst_i[p]});
          void'(local_m[p].pop_front());
        end
        if (remote_pop_i[p] && remote_m[p].size() > 0) begin
          compare("remote_req", p, remote_m[p][0],
                  {remote_aggr_i[p], remote_id_i[p], remote_src_i[p]});
          void'(remote_m[p].pop_front());
        end
        if (push_l && !l_full) local_m[p].push_back(rsp);   // full queue drops it.
        if (push_r && !r_full) remote_m[p].push_back(req);
      end
    end
  end

endmodule

`default_nettype wire

/* fsync_cc_tb.sv */
// Sync core testbench
`timescale 1ns/10ps
`default_nettype none

module fsync_cc_tb;

  localparam int N_IDS         = 6;
  localparam int FIFO_DEPTH    = 4;
  localparam int NP            = fsync_pkg::N_PORTS;
  localparam int AW            = fsync_pkg::AGGR_WIDTH;
  localparam int IW            = fsync_pkg::ID_WIDTH;
  localparam int SW            = fsync_pkg::SD_WIDTH;
  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 2;

  // --------------------
  // phase lengths.
  // --------------------
  localparam int IDLE_CYCLES   = 4;
  localparam int ROOT_CYCLES   = 200;
  localparam int REMOTE_CYCLES = 200;
  localparam int PAIR_CYCLES   = 120;
  localparam int ERR_CYCLES    = 200;
  localparam int FULL_CYCLES   = 120;
  localparam int DRAIN_CYCLES  = 40;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + ROOT_CYCLES + REMOTE_CYCLES
                               + PAIR_CYCLES + ERR_CYCLES + FULL_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_NS    = (TOTAL_CYCLES + 100) * CLK_PERIOD;

  logic              clk;
  logic              rst_n;
  logic [2:0]        phase;
  logic              req_valid      [NP];
  logic [AW-1:0]     req_aggr       [NP];
  logic [IW-1:0]     req_id         [NP];
  logic [SW-1:0]     req_src        [NP];
  logic              root           [NP];
  logic              local_pop      [NP];
  logic              remote_pop     [NP];
  logic              local_empty    [NP];
  logic              local_error    [NP];
  logic [SW-1:0]     local_dst      [NP];
  logic              remote_empty   [NP];
  logic [AW-1:0]     remote_aggr    [NP];
  logic [IW-1:0]     remote_id      [NP];
  logic [SW+1:0]     remote_src     [NP];
  logic              detected_error [NP];
  int                error_count;
  logic [15:0]       lfsr;

  fsync_cc #(.N_IDS(N_IDS), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
    .clk_i(clk), .rst_ni(rst_n), .req_valid_i(req_valid), .req_aggr_i(req_aggr),
    .req_id_i(req_id), .req_src_i(req_src), .root_i(root), .local_pop_i(local_pop),
    .remote_pop_i(remote_pop), .local_empty_o(local_empty), .local_error_o(local_error),
    .local_dst_o(local_dst), .remote_empty_o(remote_empty), .remote_aggr_o(remote_aggr),
    .remote_id_o(remote_id), .remote_src_o(remote_src), .detected_error_o(detected_error)
  );

  fsync_cc_checker #(.N_IDS(N_IDS), .FIFO_DEPTH(FIFO_DEPTH)) i_checker (
    .clk_i(clk), .rst_ni(rst_n), .phase_i(phase), .req_valid_i(req_valid),
    .req_aggr_i(req_aggr), .req_id_i(req_id), .req_src_i(req_src), .root_i(root),
    .local_pop_i(local_pop), .remote_pop_i(remote_pop), .local_empty_i(local_empty),
    .local_error_i(local_error), .local_dst_i(local_dst), .remote_empty_i(remote_empty),
    .remote_aggr_i(remote_aggr), .remote_id_i(remote_id), .remote_src_i(remote_src),
    .detected_error_i(detected_error), .error_count_o(error_count)
  );

  bind fsync_ctrl fsync_cc_props i_props (
    .clk_i(clk_i), .rst_ni(rst_ni), .state_i(state_q), .req_valid_i(req_valid_i),
    .push_local_i(push_local_o), .push_remote_i(push_remote_o),
    .local_empty_i(local_empty_i), .remote_empty_i(remote_empty_i),
    .error_i(detected_error_o)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic int lfsr_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
    return v;
  endfunction

  // --------------------
  // random traffic, changes on the falling edge.
  // --------------------
  // root_mode 0 low, 1 high, 2 random. pops fire when pop_weight bits are all zero.
  task automatic drive_phase(input logic [2:0] ph, input int cycles, input bit req_on,
                             input int root_mode, input int id_width, input bit paired,
                             input int pop_weight);
    bit sent [NP];
    for (int p = 0; p < NP; p++) sent[p] = req_valid[p];  // last strobe of the prior phase.
    if (paired) sent[0] = sent[0] | sent[1];  // port 1 follows port 0.
    repeat (cycles) begin
      @(negedge clk);
      phase = ph;
      for (int p = 0; p < NP; p++) begin
        req_valid[p]  = req_on && !sent[p] && lfsr_bit();  // never two cycles in a row.
        req_aggr[p]   = AW'(lfsr_bits(AW));
        req_id[p]     = IW'(lfsr_bits(id_width));
        req_src[p]    = SW'(lfsr_bits(SW));
        root[p]       = (root_mode == 2) ? lfsr_bit() : (root_mode == 1);
        local_pop[p]  = (lfsr_bits(pop_weight) == 0);
        remote_pop[p] = (lfsr_bits(pop_weight) == 0);
        sent[p]       = req_valid[p];
      end
      if (paired) begin
        req_valid[1] = req_valid[0];  // both ports hit one entry together.
        req_aggr[1]  = req_aggr[0];
        req_id[1]    = req_id[0];
        sent[1]      = sent[0];
      end
    end
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("tb: timeout after %0d ns, stimulus never finished", TIMEOUT_NS);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    lfsr  = 16'd47;
    rst_n = 1'b0;
    phase = 3'd0;
    for (int p = 0; p < NP; p++) begin
      req_valid[p]  = 1'b0;
      req_aggr[p]   = '0;
      req_id[p]     = '0;
      req_src[p]    = '0;
      root[p]       = 1'b0;
      local_pop[p]  = 1'b0;
      remote_pop[p] = 1'b0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (IDLE_CYCLES) @(negedge clk);  // quiet cycles, all queues empty.
    drive_phase(3'd1, ROOT_CYCLES, 1'b1, 1, 1, 1'b0, 1);
    drive_phase(3'd2, REMOTE_CYCLES, 1'b1, 0, 1, 1'b0, 1);
    drive_phase(3'd3, PAIR_CYCLES, 1'b1, 0, 2, 1'b1, 1);
    drive_phase(3'd4, ERR_CYCLES, 1'b1, 2, IW, 1'b0, 1);
    drive_phase(3'd5, FULL_CYCLES, 1'b1, 2, 1, 1'b0, 3);
    drive_phase(3'd6, DRAIN_CYCLES, 1'b0, 0, 1, 1'b0, 0);
    @(negedge clk);
    $display("tb: run done, %0d error(s)", error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
fsync_pkg.sv
fsync_rf_if.sv
fsync_req_decode.sv
fsync_ctrl.sv
fsync_rf.sv
fsync_fifo.sv
fsync_cc.sv
fsync_cc_props.sv
fsync_cc_checker.sv
fsync_cc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sync core testbench with Verilator.
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module fsync_cc_tb \
  -o fsync_sim > sim.log 2>&1 \
  && ./obj_dir/fsync_sim >> sim.log 2>&1 \
  || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
